/* Makefile */
VERILATOR  ?= verilator
FILELIST   := sim.f
TB_TOP     := tb_top
RTL_TOP    := rp_analog_top
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -j 0
FAIL_MSG   := Test failed
PASS_MSG   := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_checker.sv */
// Reference model and scoreboard for the analog signal path
// Watches the DUT ports on every rising edge, predicts each output from the
// data format rules and prints the error counts once report_i is raised

`timescale 1ns/1ps
`include "rp_cfg.svh"

module tb_checker (
  input  logic                  adc_clk,
  input  logic                  adc_rstn,
  input  rp_dat_pkg::adc_raw_t  adc_a_dat_i,
  input  rp_dat_pkg::adc_raw_t  adc_b_dat_i,
  input  logic                  digital_loop_i,
  input  rp_dat_pkg::smp_t      asg_a_i,
  input  rp_dat_pkg::smp_t      asg_b_i,
  input  rp_dat_pkg::smp_t      pid_a_i,
  input  rp_dat_pkg::smp_t      pid_b_i,
  input  rp_dat_pkg::smp_t      adc_a_i,      // DUT outputs from here
  input  rp_dat_pkg::smp_t      adc_b_i,
  input  rp_dat_pkg::dac_code_t dac_a_dat_i,
  input  rp_dat_pkg::dac_code_t dac_b_dat_i,
  input  logic                  report_i,     // Print summary at next edge
  output logic                  armed_o,      // Reset edge seen, checks live
  output logic                  reported_o,
  output int                    err_cnt_o
);

  import rp_dat_pkg::*;
  import rp_avg_pkg::*;

  localparam int DEPTH = 1 << `RP_AVG_LOG2;
  localparam int SMP_MAX = (1 << (`RP_SMP_W-1)) - 1;  // 8191
  localparam int SMP_MIN = -(1 << (`RP_SMP_W-1));     // -8192
  localparam dac_code_t NS_MASK = dac_code_t'(SMP_MAX); // Low 13 bits flip

  ////////////////////
  // Format rules
  ////////////////////

  function automatic int sat_sum(input smp_t x, input smp_t y);
    int s;
    s = int'(x) + int'(y);
    if (s > SMP_MAX) s = SMP_MAX;
    else if (s < SMP_MIN) s = SMP_MIN;
    return s;
  endfunction

  // Same rule both directions
  function automatic dac_code_t flip_slope(input logic [`RP_SMP_W-1:0] w);
    return w ^ NS_MASK;
  endfunction

  // Round toward minus infinity
  function automatic int floor_div(input int s);
    int q;
    q = s / DEPTH;
    if (s < 0 && (s % DEPTH) != 0) q = q - 1;
    return q;
  endfunction

  function automatic bit check_val(input string what, input logic [`RP_SMP_W-1:0] got,
                                   input logic [`RP_SMP_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got 0x%h expected 0x%h", $time, what, got, exp);
      return 1'b1;
    end
    return 1'b0;
  endfunction

  ////////////////////
  // Model state
  ////////////////////

  logic [`RP_SMP_W-1:0] m_raw_a;  // Captured bits 15..2
  logic [`RP_SMP_W-1:0] m_raw_b;
  dac_code_t m_dac_a;
  dac_code_t m_dac_b;
  int        m_hist [DEPTH];      // Last 64 CH A mix samples
  avg_idx_t  m_idx;
  int        m_sum;               // Exact window sum
  logic      armed = 1'b0;
  logic      reported = 1'b0;
  int        n_checks = 0;
  int        n_adc_err = 0;
  int        n_dac_a_err = 0;
  int        n_dac_b_err = 0;

  assign armed_o    = armed;
  assign reported_o = reported;
  assign err_cnt_o  = n_adc_err + n_dac_a_err + n_dac_b_err;

  // Pre-edge values throughout, DUT registers update after this block reads
  always @(posedge adc_clk) begin
    int mix_a;
    int mix_b;
    logic [`RP_SMP_W-1:0] exp_a;
    logic [`RP_SMP_W-1:0] exp_b;
    mix_a = sat_sum(asg_a_i, pid_a_i);
    mix_b = sat_sum(asg_b_i, pid_b_i);
    if (armed) begin
      exp_a = digital_loop_i ? smp_t'(mix_a) : flip_slope(m_raw_a);  // Loop is same cycle
      exp_b = digital_loop_i ? smp_t'(mix_b) : flip_slope(m_raw_b);
      n_adc_err   = n_adc_err + int'(check_val("adc_a_o", adc_a_i, exp_a));
      n_adc_err   = n_adc_err + int'(check_val("adc_b_o", adc_b_i, exp_b));
      n_dac_a_err = n_dac_a_err + int'(check_val("dac_a_dat_o", dac_a_dat_i, m_dac_a));
      n_dac_b_err = n_dac_b_err + int'(check_val("dac_b_dat_o", dac_b_dat_i, m_dac_b));
      n_checks    = n_checks + 4;
    end
    if (!adc_rstn) begin
      m_raw_a = '0;
      m_raw_b = '0;
      m_dac_a = '0;  // DAC pins read 0 in reset
      m_dac_b = '0;
      for (int i = 0; i < DEPTH; i++) m_hist[i] = 0;
      m_idx = '0;
      m_sum = 0;
      armed = 1'b1;
    end else begin
      m_raw_a = adc_a_dat_i[`RP_ADC_RAW_W-1:2];  // Reserved LSBs dropped
      m_raw_b = adc_b_dat_i[`RP_ADC_RAW_W-1:2];
      m_dac_a = flip_slope(smp_t'(floor_div(m_sum)));  // Mean from the old sum
      m_dac_b = flip_slope(smp_t'(mix_b));
      m_sum   = m_sum + mix_a - m_hist[m_idx];  // Oldest leaves window
      m_hist[m_idx] = mix_a;
      m_idx   = m_idx + 1'b1;
    end
    if (report_i && !reported) begin
      $display("Summary: %0d checks, %0d adc errors, %0d dac_a errors, %0d dac_b errors",
               n_checks, n_adc_err, n_dac_a_err, n_dac_b_err);
      reported = 1'b1;
    end
  end

endmodule

/* dv/tb_top.sv */
// Top-level testbench for the analog signal path
// Applies a stimulus table on falling edges, tb_checker predicts and
// compares every output and the final verdict is printed here

`timescale 1ns/1ps

module tb_top;

  import rp_dat_pkg::*;

  localparam int N_ROWS         = 12;
  localparam int ARM_TIMEOUT    = 20;  // Cycles
  localparam int REPORT_TIMEOUT = 20;
  localparam int DRAIN_CYCLES   = 3;   // CH A needs two edges
  localparam logic [31:0] SEED  = 32'hb0e9;

  typedef struct packed {
    adc_raw_t   raw_a;
    adc_raw_t   raw_b;
    smp_t       asg_a;
    smp_t       asg_b;
    smp_t       pid_a;
    smp_t       pid_b;
    logic       loop;   // digital_loop_i level
    logic       rnd;    // Draw fresh values each repeat
    logic [7:0] reps;
  } stim_t;

  logic      adc_clk;
  logic      adc_rstn;
  adc_raw_t  adc_a_dat;
  adc_raw_t  adc_b_dat;
  logic      digital_loop;
  smp_t      asg_a, asg_b, pid_a, pid_b;
  smp_t      adc_a, adc_b;
  dac_code_t dac_a_dat, dac_b_dat;
  logic      report;
  logic      armed, reported;
  int        err_cnt;
  stim_t     tbl [N_ROWS];

  initial begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;  // 4 ns period
  end

  rp_analog_top dut (
    .adc_clk (adc_clk), .adc_rstn (adc_rstn),
    .adc_a_dat_i (adc_a_dat), .adc_b_dat_i (adc_b_dat),
    .adc_a_o (adc_a), .adc_b_o (adc_b),
    .digital_loop_i (digital_loop),
    .asg_a_i (asg_a), .asg_b_i (asg_b), .pid_a_i (pid_a), .pid_b_i (pid_b),
    .dac_a_dat_o (dac_a_dat), .dac_b_dat_o (dac_b_dat)
  );

  tb_checker chk (
    .adc_clk (adc_clk), .adc_rstn (adc_rstn),
    .adc_a_dat_i (adc_a_dat), .adc_b_dat_i (adc_b_dat),
    .digital_loop_i (digital_loop),
    .asg_a_i (asg_a), .asg_b_i (asg_b), .pid_a_i (pid_a), .pid_b_i (pid_b),
    .adc_a_i (adc_a), .adc_b_i (adc_b),
    .dac_a_dat_i (dac_a_dat), .dac_b_dat_i (dac_b_dat),
    .report_i (report), .armed_o (armed), .reported_o (reported), .err_cnt_o (err_cnt)
  );

  ////////////////////
  // Stimulus table
  ////////////////////

  function automatic stim_t make_row(input adc_raw_t ra, input adc_raw_t rb, input int aa,
                                     input int ab, input int pa, input int pb,
                                     input logic lp, input logic rn, input int n);
    return '{ra, rb, smp_t'(aa), smp_t'(ab), smp_t'(pa), smp_t'(pb), lp, rn, n[7:0]};
  endfunction

  task automatic load_table();
    tbl[0]  = make_row(16'h0000, 16'h0000,     0,     0,    0,    0, 0, 0, 4);   // Raw zero
    tbl[1]  = make_row(16'hFFFF, 16'hFFFF,   100,  -100,   20,  -20, 0, 0, 4);
    tbl[2]  = make_row(16'h8003, 16'h7FFC,  8000,  8000,  500, 1000, 0, 0, 3);   // Above 8191
    tbl[3]  = make_row(16'h1234, 16'hABCD, -8000, -8000, -500, -1000, 0, 0, 3);  // Below -8192
    tbl[4]  = make_row(16'h5555, 16'hAAAA,  1000, -3000, -250, 2999, 0, 0, 3);
    tbl[5]  = make_row(16'h0000, 16'h0000,   100,  5000,  -50, 4000, 1, 0, 4);   // Loop mode
    tbl[6]  = make_row(16'hFFFF, 16'h0000, -6000,    -1, -6000,   1, 1, 0, 4);
    tbl[7]  = make_row(16'h0000, 16'h0000,  8000,     0,  500,    0, 0, 0, 70);  // v = 8191
    tbl[8]  = make_row(16'h0000, 16'h0000, -8192,     0, -100,    0, 0, 0, 70);  // v = -8192
    tbl[9]  = make_row(16'h0000, 16'h0000,     0,     0,    0,    0, 0, 1, 100);
    tbl[10] = make_row(16'h0000, 16'h0000,     0,     0,    0,    0, 1, 1, 40);
    tbl[11] = make_row(16'h0000, 16'h0000,     0,     0,    0,    0, 0, 1, 100);
  endtask

  task automatic drive_row(input stim_t row);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    if (row.rnd) begin
      r0 = $urandom();
      r1 = $urandom();
      r2 = $urandom();
      adc_a_dat = r0[15:0];
      adc_b_dat = r0[31:16];
      asg_a     = r1[13:0];   // Full range, saturates often
      asg_b     = r1[29:16];
      pid_a     = r2[13:0];
      pid_b     = r2[29:16];
    end else begin
      adc_a_dat = row.raw_a;
      adc_b_dat = row.raw_b;
      asg_a     = row.asg_a;
      asg_b     = row.asg_b;
      pid_a     = row.pid_a;
      pid_b     = row.pid_b;
    end
    digital_loop = row.loop;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    bit ok;
    adc_rstn = 1'b0;
    adc_a_dat = '0;
    adc_b_dat = '0;
    digital_loop = 1'b0;
    asg_a = '0;
    asg_b = '0;
    pid_a = '0;
    pid_b = '0;
    report = 1'b0;
    void'($urandom(SEED));  // Seed once
    load_table();
    repeat (4) @(negedge adc_clk);  // 4 reset cycles
    for (int i = 0; i < ARM_TIMEOUT && !armed; i++) @(negedge adc_clk);
    ok = armed;
    if (!ok) $display("Timeout: checker never saw the reset edge");
    if (ok) begin
      adc_rstn = 1'b1;
      for (int r = 0; r < N_ROWS; r++) begin
        for (int k = 0; k < int'(tbl[r].reps); k++) begin
          @(negedge adc_clk);
          drive_row(tbl[r]);
        end
      end
      repeat (DRAIN_CYCLES) @(negedge adc_clk);  // Let the last samples reach the pins
      report = 1'b1;
      for (int i = 0; i < REPORT_TIMEOUT && !reported; i++) @(negedge adc_clk);
      ok = reported;
      if (!ok) $display("Timeout: checker did not print its summary");
    end
    if (ok && err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* hw/rp_adc_frontend.sv */
// ADC front end for both channels
// Registers the pin words, drops the reserved LSBs and converts the
// negative-slope code to two's complement. Loop mode bypasses the ADC.

`timescale 1ns/1ps
`include "rp_cfg.svh"

module rp_adc_frontend (
  input  logic                adc_clk,
  input  logic                adc_rstn,        // Sync, active low
  input  rp_dat_pkg::adc_raw_t adc_a_dat_i,    // ADC pins CH A
  input  rp_dat_pkg::adc_raw_t adc_b_dat_i,    // ADC pins CH B
  input  logic                digital_loop_i,  // Replace ADC with DAC mix
  input  rp_dat_pkg::smp_t    loop_a_i,        // Mix CH A
  input  rp_dat_pkg::smp_t    loop_b_i,        // Mix CH B
  output rp_dat_pkg::smp_t    adc_a_o,
  output rp_dat_pkg::smp_t    adc_b_o
);

  import rp_dat_pkg::*;

  ////////////////////
  // Pin capture
  ////////////////////

  smp_t adc_a_raw_q;  // Still negative slope here
  smp_t adc_b_raw_q;

  // Bits 1..0 are reserved on the 16 bit ADC
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      adc_a_raw_q <= '0;
      adc_b_raw_q <= '0;
    end else begin
      adc_a_raw_q <= adc_a_dat_i[`RP_ADC_RAW_W-1 -: `RP_SMP_W];
      adc_b_raw_q <= adc_b_dat_i[`RP_ADC_RAW_W-1 -: `RP_SMP_W];
    end
  end

  ////////////////////
  // Conversion and loop select
  ////////////////////

  smp_t adc_a_cnv;
  smp_t adc_b_cnv;

  // Keep MSB, invert the rest
  assign adc_a_cnv = {adc_a_raw_q[`RP_SMP_W-1], ~adc_a_raw_q[`RP_SMP_W-2:0]};
  assign adc_b_cnv = {adc_b_raw_q[`RP_SMP_W-1], ~adc_b_raw_q[`RP_SMP_W-2:0]};

  // Loop data is taken in the same cycle
  assign adc_a_o = digital_loop_i ? loop_a_i : adc_a_cnv;
  assign adc_b_o = digital_loop_i ? loop_b_i : adc_b_cnv;

endmodule

/* hw/rp_analog_top.sv */
// Analog signal path top level in the adc_clk domain
// ADC capture, generator/controller mix, CH A averaging and DAC output.
// Generator and controller samples come in as plain ports.

`timescale 1ns/1ps

module rp_analog_top (
  input  logic                  adc_clk,
  input  logic                  adc_rstn,        // Sync, active low
  // ADC
  input  rp_dat_pkg::adc_raw_t  adc_a_dat_i,
  input  rp_dat_pkg::adc_raw_t  adc_b_dat_i,
  output rp_dat_pkg::smp_t      adc_a_o,         // To scope/controller
  output rp_dat_pkg::smp_t      adc_b_o,
  // Config
  input  logic                  digital_loop_i,  // Feed mix back as ADC data
  // Generator and controller
  input  rp_dat_pkg::smp_t      asg_a_i,
  input  rp_dat_pkg::smp_t      asg_b_i,
  input  rp_dat_pkg::smp_t      pid_a_i,
  input  rp_dat_pkg::smp_t      pid_b_i,
  // DAC
  output rp_dat_pkg::dac_code_t dac_a_dat_o,
  output rp_dat_pkg::dac_code_t dac_b_dat_o
);

  import rp_dat_pkg::*;

  smp_t mix_a;  // Saturated sums
  smp_t mix_b;
  smp_t avg_a;  // CH A window mean

  ////////////////////
  // ADC side
  ////////////////////

  rp_adc_frontend u_frontend (
    .adc_clk        (adc_clk),
    .adc_rstn       (adc_rstn),
    .adc_a_dat_i    (adc_a_dat_i),
    .adc_b_dat_i    (adc_b_dat_i),
    .digital_loop_i (digital_loop_i),
    .loop_a_i       (mix_a),  // Loopback source
    .loop_b_i       (mix_b),
    .adc_a_o        (adc_a_o),
    .adc_b_o        (adc_b_o)
  );

  ////////////////////
  // DAC side
  ////////////////////

  rp_dac_mixer u_mixer (
    .asg_a_i (asg_a_i),
    .asg_b_i (asg_b_i),
    .pid_a_i (pid_a_i),
    .pid_b_i (pid_b_i),
    .mix_a_o (mix_a),
    .mix_b_o (mix_b)
  );

  // CH A only
  rp_moving_avg u_avg (
    .adc_clk  (adc_clk),
    .adc_rstn (adc_rstn),
    .smp_i    (mix_a),
    .avg_o    (avg_a)
  );

  rp_dac_backend u_backend (
    .adc_clk     (adc_clk),
    .adc_rstn    (adc_rstn),
    .dac_a_i     (avg_a),
    .dac_b_i     (mix_b),  // CH B skips the averager
    .dac_a_dat_o (dac_a_dat_o),
    .dac_b_dat_o (dac_b_dat_o)
  );

endmodule

/* hw/rp_avg_pkg.sv */
// Types for the channel A moving average
// Used by the averager and by the testbench model

`include "rp_cfg.svh"

package rp_avg_pkg;

  // Running sum of the whole window
  typedef logic signed [`RP_ACC_W-1:0] avg_acc_t;

  // Slot pointer into the history ring
  typedef logic [`RP_AVG_LOG2-1:0] avg_idx_t;

endpackage

/* hw/rp_cfg.svh */
// Width and depth settings for the analog signal path
// Included by both packages and by every RTL module that slices samples

`ifndef RP_CFG_SVH
`define RP_CFG_SVH

////////////////////
// ADC pin format
////////////////////

`define RP_ADC_RAW_W 16  // Raw ADC word incl. two reserved LSBs

////////////////////
// Sample path
////////////////////

`define RP_SMP_W     14  // Converter resolution
`define RP_SUM_W     15  // Generator plus controller before saturation

////////////////////
// Moving average
////////////////////

`define RP_AVG_LOG2  6   // 64 sample window
`define RP_ACC_W     20  // RP_SMP_W + RP_AVG_LOG2 so the running sum never wraps

`endif

/* hw/rp_dac_backend.sv */
// DAC output stage for both channels
// Registers the samples and turns two's complement into the
// negative-slope offset code the DAC expects

`timescale 1ns/1ps
`include "rp_cfg.svh"

module rp_dac_backend (
  input  logic                  adc_clk,
  input  logic                  adc_rstn,     // Sync, active low
  input  rp_dat_pkg::smp_t      dac_a_i,      // Averaged CH A
  input  rp_dat_pkg::smp_t      dac_b_i,      // Mixed CH B
  output rp_dat_pkg::dac_code_t dac_a_dat_o,  // DAC pins CH A
  output rp_dat_pkg::dac_code_t dac_b_dat_o   // DAC pins CH B
);

  ////////////////////
  // Output registers
  ////////////////////

  // MSB kept, lower bits inverted
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_a_dat_o <= '0;
      dac_b_dat_o <= '0;
    end else begin
      dac_a_dat_o <= {dac_a_i[`RP_SMP_W-1], ~dac_a_i[`RP_SMP_W-2:0]};
      dac_b_dat_o <= {dac_b_i[`RP_SMP_W-1], ~dac_b_i[`RP_SMP_W-2:0]};
    end
  end

  // Both channels leave separately, no interleaving here

endmodule

/* hw/rp_dac_mixer.sv */
// Sums generator and controller samples per DAC channel
// The 15 bit sum is clipped to the 14 bit DAC range. Purely combinational.

`timescale 1ns/1ps
`include "rp_cfg.svh"

module rp_dac_mixer (
  input  rp_dat_pkg::smp_t asg_a_i,  // Generator CH A
  input  rp_dat_pkg::smp_t asg_b_i,  // Generator CH B
  input  rp_dat_pkg::smp_t pid_a_i,  // Controller CH A
  input  rp_dat_pkg::smp_t pid_b_i,  // Controller CH B
  output rp_dat_pkg::smp_t mix_a_o,
  output rp_dat_pkg::smp_t mix_b_o
);

  import rp_dat_pkg::*;

  ////////////////////
  // Saturation
  ////////////////////

  // Top two bits differ when the sum left the 14 bit range
  function automatic smp_t sat_smp(input mix_sum_t sum);
    logic sign;
    sign = sum[`RP_SUM_W-1];
    if (sum[`RP_SUM_W-1] != sum[`RP_SUM_W-2]) begin
      sat_smp = {sign, {(`RP_SMP_W-1){~sign}}};  // 8191 or -8192
    end else begin
      sat_smp = sum[`RP_SMP_W-1:0];  // In range, drop the extra bit
    end
  endfunction

  ////////////////////
  // Summation
  ////////////////////

  mix_sum_t sum_a;
  mix_sum_t sum_b;

  // Sign extend before adding so no carry is lost
  assign sum_a = mix_sum_t'(asg_a_i) + mix_sum_t'(pid_a_i);
  assign sum_b = mix_sum_t'(asg_b_i) + mix_sum_t'(pid_b_i);

  assign mix_a_o = sat_smp(sum_a);  // To averager and loopback
  assign mix_b_o = sat_smp(sum_b);  // To DAC B and loopback

endmodule

/* hw/rp_dat_pkg.sv */
// Data format types for the ADC pins, internal samples and DAC codes
// Ports name these by scope, module bodies import the package

`include "rp_cfg.svh"

package rp_dat_pkg;

  // Word as it arrives on the ADC pins
  typedef logic [`RP_ADC_RAW_W-1:0] adc_raw_t;

  // Internal sample in two's complement
  typedef logic signed [`RP_SMP_W-1:0] smp_t;

  // Negative-slope offset binary code for the DAC pins
  typedef logic [`RP_SMP_W-1:0] dac_code_t;

  // One bit of headroom for the asg + pid sum
  typedef logic signed [`RP_SUM_W-1:0] mix_sum_t;

endpackage

/* hw/rp_moving_avg.sv */
// Running-sum moving average over the last 64 samples
// One sample per clock. Output is the floor of sum / 64 from the sum register.

`timescale 1ns/1ps
`include "rp_cfg.svh"

module rp_moving_avg (
  input  logic             adc_clk,
  input  logic             adc_rstn,  // Sync, active low
  input  rp_dat_pkg::smp_t smp_i,     // New sample every cycle
  output rp_dat_pkg::smp_t avg_o      // Window mean
);

  import rp_dat_pkg::*;
  import rp_avg_pkg::*;

  localparam int AVG_DEPTH = 1 << `RP_AVG_LOG2;

  ////////////////////
  // State
  ////////////////////

  smp_t     hist_q [AVG_DEPTH];  // Sample ring
  avg_idx_t idx_q;               // Oldest slot, overwritten next
  avg_acc_t acc_q;               // Sum of the whole ring

  avg_acc_t acc_nxt;

  // Add newest, drop the one that leaves the window
  assign acc_nxt = acc_q + avg_acc_t'(smp_i) - avg_acc_t'(hist_q[idx_q]);

  ////////////////////
  // Update
  ////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      for (int i = 0; i < AVG_DEPTH; i++) begin
        hist_q[i] <= '0;  // Empty window reads as zero
      end
      idx_q <= '0;
      acc_q <= '0;
    end else begin
      hist_q[idx_q] <= smp_i;
      idx_q         <= idx_q + 1'b1;  // Wraps at 64 by width
      acc_q         <= acc_nxt;
    end
  end

  // Arithmetic shift by the window size is a plain slice
  assign avg_o = acc_q[`RP_ACC_W-1:`RP_AVG_LOG2];

endmodule

/* sim.f */
+incdir+hw
hw/rp_dat_pkg.sv
hw/rp_avg_pkg.sv
hw/rp_adc_frontend.sv
hw/rp_dac_mixer.sv
hw/rp_moving_avg.sv
hw/rp_dac_backend.sv
hw/rp_analog_top.sv
dv/tb_checker.sv
dv/tb_top.sv
